/* all.f */
source/eeprom_pkg.sv
source/i2c_bit_engine.sv
source/eeprom_ctrl.sv
source/eeprom_wr_top.sv
testbench/eeprom_model.sv
testbench/eeprom_wr_checker.sv
testbench/eeprom_wr_tb.sv

/* source/eeprom_ctrl.sv */
`timescale 1ns/100ps

module eeprom_ctrl
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        req_valid,
    input  eeprom_req_t req,
    output logic        busy,
    output logic        done,
    output eeprom_rsp_t rsp,
    output logic        cmd_valid,
    output bit_cmd_t    cmd,
    input  logic        cmd_done,
    input  bit_rsp_t    bit_rsp
);

    ctrl_state_e state;
    ctrl_state_e next_state;
    eeprom_req_t req_q;
    logic        is_read;
    logic        enter_cmd;

    function automatic bit_cmd_t bit_cmd(bit_op_e op, eeprom_data_t tx_byte);
        bit_cmd_t c;
        c.op          = op;
        c.tx_byte     = tx_byte;
        c.master_nack = 1'b1;       // only one byte is ever read
        return c;
    endfunction

    // device code, block bits, r/w
    function automatic eeprom_data_t ctrl_byte(eeprom_addr_t addr, logic rd);
        return {CTRL_DEVICE_CODE, addr[ADDR_W-1:DATA_W], rd};
    endfunction

    assign is_read = (req_q.op == OP_READ);

    assign busy = (state != CST_IDLE) && (state != CST_DONE);
    assign done = (state == CST_DONE);

    // new command on every entry into a bus state
    assign enter_cmd = (next_state != state) &&
                       (next_state != CST_IDLE) && (next_state != CST_DONE);

    always_comb
    begin
        next_state = state;
        case (state)
            CST_IDLE:
                if (req_valid)
                    next_state = CST_START;
            CST_START:
                if (cmd_done)
                    next_state = CST_CTRL_WR;
            CST_CTRL_WR:
                if (cmd_done)
                    next_state = bit_rsp.slave_nack ? CST_STOP : CST_ADDR;
            CST_ADDR:
                if (cmd_done)
                begin
                    if (bit_rsp.slave_nack)
                        next_state = CST_STOP;
                    else if (is_read)
                        next_state = CST_RESTART;   // dummy write done
                    else
                        next_state = CST_DATA_WR;
                end
            CST_DATA_WR:
                if (cmd_done)
                    next_state = CST_STOP;
            CST_RESTART:
                if (cmd_done)
                    next_state = CST_CTRL_RD;
            CST_CTRL_RD:
                if (cmd_done)
                    next_state = bit_rsp.slave_nack ? CST_STOP : CST_DATA_RD;
            CST_DATA_RD:
                if (cmd_done)
                    next_state = CST_STOP;
            CST_STOP:
                if (cmd_done)
                    next_state = CST_DONE;
            default:
                next_state = CST_IDLE;   // done lasts one cycle, strobes here are dropped
        endcase
    end

    // command payload follows the state it was issued for
    always_comb
    begin
        case (state)
            CST_START,
            CST_RESTART: cmd = bit_cmd(BIT_START, '0);
            CST_CTRL_WR: cmd = bit_cmd(BIT_WR_BYTE, ctrl_byte(req_q.addr, 1'b0));
            CST_ADDR:    cmd = bit_cmd(BIT_WR_BYTE, req_q.addr[DATA_W-1:0]);
            CST_DATA_WR: cmd = bit_cmd(BIT_WR_BYTE, req_q.wdata);
            CST_CTRL_RD: cmd = bit_cmd(BIT_WR_BYTE, ctrl_byte(req_q.addr, 1'b1));
            CST_DATA_RD: cmd = bit_cmd(BIT_RD_BYTE, '0);
            default:     cmd = bit_cmd(BIT_STOP, '0);
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= CST_IDLE;
            cmd_valid <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            cmd_valid <= enter_cmd;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == CST_IDLE && req_valid)
        begin
            req_q    <= req;
            rsp.nack <= 1'b0;
        end
        else if (cmd_done)
        begin
            rsp.nack <= rsp.nack | bit_rsp.slave_nack;   // sticky over the transfer
            if (state == CST_DATA_RD)
                rsp.rdata <= bit_rsp.rx_byte;
        end
    end

endmodule

/* source/eeprom_pkg.sv */
package eeprom_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] eeprom_addr_t;   // bits 10:8 pick the 256 byte block
    typedef logic [DATA_W-1:0] eeprom_data_t;

    localparam logic [3:0] CTRL_DEVICE_CODE = 4'b1010;

    // position inside one bus bit, scl is high in the upper half
    typedef logic [1:0] bit_phase_t;
    localparam bit_phase_t PH_CHANGE = 2'd0;    // sda update decided here
    localparam bit_phase_t PH_HIGH   = 2'd2;
    localparam bit_phase_t PH_SAMPLE = 2'd3;

    typedef enum logic {OP_WRITE, OP_READ} eeprom_op_e;

    typedef struct packed {
        eeprom_op_e   op;
        eeprom_addr_t addr;
        eeprom_data_t wdata;
    } eeprom_req_t;

    typedef struct packed {
        eeprom_data_t rdata;
        logic         nack;
    } eeprom_rsp_t;

    typedef enum logic [1:0] {BIT_START, BIT_STOP, BIT_WR_BYTE, BIT_RD_BYTE} bit_op_e;

    typedef struct packed {
        bit_op_e      op;
        eeprom_data_t tx_byte;
        logic         master_nack;   // ack slot level on reads, 1 releases sda
    } bit_cmd_t;

    typedef struct packed {
        eeprom_data_t rx_byte;
        logic         slave_nack;
    } bit_rsp_t;

    typedef enum logic [3:0] {
        CST_IDLE, CST_START, CST_CTRL_WR, CST_ADDR, CST_DATA_WR,
        CST_RESTART, CST_CTRL_RD, CST_DATA_RD, CST_STOP, CST_DONE
    } ctrl_state_e;

    typedef enum logic [2:0] {BST_IDLE, BST_START, BST_SHIFT, BST_ACK, BST_STOP} bit_state_e;

endpackage

/* source/eeprom_wr_top.sv */
`timescale 1ns/100ps

module eeprom_wr_top
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        req_valid,
    input  eeprom_req_t req,
    output logic        busy,
    output logic        done,
    output eeprom_rsp_t rsp,
    output logic        scl,
    inout  wire         sda
);

    logic     cmd_valid;
    bit_cmd_t cmd;
    logic     cmd_done;
    bit_rsp_t bit_rsp;
    logic     sda_drive_low;

    // open drain, the pull-up is outside
    assign sda = sda_drive_low ? 1'b0 : 1'bz;

    eeprom_ctrl u_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_done  (cmd_done),
        .bit_rsp   (bit_rsp)
    );

    i2c_bit_engine u_bit (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_done      (cmd_done),
        .bit_rsp       (bit_rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda)           // read back from the pin
    );

endmodule

/* source/i2c_bit_engine.sv */
`timescale 1ns/100ps

module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     cmd_valid,
    input  bit_cmd_t cmd,
    output logic     cmd_done,
    output bit_rsp_t bit_rsp,
    output logic     scl,
    output logic     sda_drive_low,
    input  logic     sda_in
);

    bit_state_e   state;
    bit_phase_t   phase;
    logic [2:0]   bit_cnt;
    eeprom_data_t shreg;
    logic         rd_byte;      // current byte is shifted in
    logic         mst_nack;

    // scl parks high between commands
    assign scl = (state == BST_IDLE) | phase[1];

    assign cmd_done = (phase == PH_SAMPLE) &&
                      (state == BST_START || state == BST_STOP || state == BST_ACK);

    assign bit_rsp.rx_byte    = shreg;
    assign bit_rsp.slave_nack = (state == BST_ACK) && !rd_byte && sda_in;

    // free running inside a command, restarts at every new one
    always_ff @(posedge CLK)
    begin
        if (RESET || state == BST_IDLE)
            phase <= PH_CHANGE;
        else
            phase <= phase + 2'd1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= BST_IDLE;
            bit_cnt       <= '0;
            sda_drive_low <= 1'b0;
            rd_byte       <= 1'b0;
        end
        else
        begin
            case (state)
                BST_IDLE:
                begin
                    bit_cnt <= '0;
                    if (cmd_valid)
                    begin
                        rd_byte <= (cmd.op == BIT_RD_BYTE);
                        case (cmd.op)
                            BIT_START: state <= BST_START;
                            BIT_STOP:  state <= BST_STOP;
                            default:   state <= BST_SHIFT;
                        endcase
                    end
                end

                // also serves as repeated start, sda released first
                BST_START:
                begin
                    if (phase == PH_CHANGE)
                        sda_drive_low <= 1'b0;
                    else if (phase == PH_HIGH)
                        sda_drive_low <= 1'b1;      // falls while scl high
                    else if (phase == PH_SAMPLE)
                        state <= BST_IDLE;
                end

                BST_SHIFT:
                begin
                    if (phase == PH_CHANGE)
                        sda_drive_low <= !rd_byte && !shreg[7];   // msb first
                    else if (phase == PH_SAMPLE)
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= BST_ACK;
                    end
                end

                // ninth slot, slave answers on writes, master answers on reads
                BST_ACK:
                begin
                    if (phase == PH_CHANGE)
                        sda_drive_low <= rd_byte && !mst_nack;
                    else if (phase == PH_SAMPLE)
                        state <= BST_IDLE;
                end

                BST_STOP:
                begin
                    if (phase == PH_CHANGE)
                        sda_drive_low <= 1'b1;
                    else if (phase == PH_HIGH)
                        sda_drive_low <= 1'b0;      // rises while scl high
                    else if (phase == PH_SAMPLE)
                        state <= BST_IDLE;
                end

                default: state <= BST_IDLE;
            endcase
        end
    end

    // one register does both directions
    always_ff @(posedge CLK)
    begin
        if (state == BST_IDLE && cmd_valid)
        begin
            shreg    <= cmd.tx_byte;
            mst_nack <= cmd.master_nack;
        end
        else if (state == BST_SHIFT && phase == PH_SAMPLE)
            shreg <= {shreg[DATA_W-2:0], sda_in};
    end

endmodule

/* testbench/eeprom_model.sv */
`timescale 1ns/100ps

module eeprom_model
    import eeprom_pkg::*;
(
    input  logic scl,
    inout  wire  sda,
    input  logic ack_enable
);

    eeprom_data_t mem [0:2047];
    eeprom_data_t shreg;
    eeprom_data_t wdata_q;
    eeprom_addr_t addr;
    logic         sda_oe;
    logic         active;
    logic         tx_mode;
    logic         rd_start;
    logic         wr_pending;
    logic [3:0]   cnt;      // scl pulses seen in the current byte
    int           byte_idx;

    assign sda = sda_oe ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = i[7:0] ^ {i[10:8], 5'd0};     // contents vary with every address bit
        sda_oe     = 1'b0;
        active     = 1'b0;
        tx_mode    = 1'b0;
        rd_start   = 1'b0;
        wr_pending = 1'b0;
        cnt        = '0;
        byte_idx   = 0;
        addr       = '0;
    end

    task automatic take_byte();
        if (!ack_enable || (byte_idx == 0 && shreg[7:4] != CTRL_DEVICE_CODE))
            active = 1'b0;      // bus left alone without an ack
        else
        begin
            case (byte_idx)
                0:
                begin
                    addr[10:8] = shreg[3:1];
                    rd_start   = shreg[0];
                end
                1: addr[7:0] = shreg;
                2:
                begin
                    wdata_q    = shreg;
                    wr_pending = 1'b1;
                end
                default: ;
            endcase
            sda_oe = 1'b1;
        end
        byte_idx++;
    endtask

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active     = 1'b1;
            tx_mode    = 1'b0;
            rd_start   = 1'b0;
            wr_pending = 1'b0;
            cnt        = '0;
            byte_idx   = 0;
            sda_oe     = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            if (wr_pending)
                mem[addr] = wdata_q;    // write cycle on stop
            wr_pending = 1'b0;
            active     = 1'b0;
            sda_oe     = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (!tx_mode && cnt < 4'd8)
                shreg = {shreg[6:0], (sda !== 1'b0)};
            cnt = cnt + 4'd1;
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (cnt == 4'd8)
            begin
                if (tx_mode)
                    sda_oe = 1'b0;      // master owns the ack slot
                else
                    take_byte();
            end
            else if (cnt == 4'd9)
            begin
                cnt    = '0;
                sda_oe = 1'b0;
                if (tx_mode)
                    active = 1'b0;      // single byte reads only
                else if (rd_start)
                begin
                    tx_mode  = 1'b1;
                    rd_start = 1'b0;
                    sda_oe   = !mem[addr][7];
                end
            end
            else if (tx_mode && cnt != 4'd0)
                sda_oe = !mem[addr][3'd7 - cnt[2:0]];
        end
    end

endmodule

/* testbench/eeprom_wr_checker.sv */
`timescale 1ns/100ps

module eeprom_wr_checker (
    input logic CLK,
    input logic RESET,
    input logic busy,
    input logic done,
    input logic scl,
    input logic sda
);

    // bus parked whenever nothing is in progress
    a_idle_bus: assert property (@(posedge CLK) disable iff (RESET)
        !busy |-> (scl == 1'b1 && sda == 1'b1))
        else $error("bus not idle while busy is low");

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
        else $error("done longer than one cycle");

    a_not_busy_after_done: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !busy)
        else $error("busy high right after done");

endmodule

/* testbench/eeprom_wr_tb.sv */
`timescale 1ns/100ps

module eeprom_wr_tb
    import eeprom_pkg::*;
();

    localparam int TIMEOUT = 1000;

    logic        CLK = 1'b0;
    logic        RESET;
    logic        req_valid;
    eeprom_req_t req;
    logic        busy;
    logic        done;
    eeprom_rsp_t rsp;
    logic        scl;
    wire         sda;
    logic        ack_enable;

    eeprom_data_t shadow [0:2047];
    logic [31:0]  lcg_state;
    eeprom_data_t exp_rdata_q [$];
    logic         exp_nack_q [$];
    logic         exp_read_q [$];
    int           done_count;
    int           issued;

    pullup (sda);

    eeprom_wr_top DUT (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp),
        .scl       (scl),
        .sda       (sda)
    );

    eeprom_model u_model (
        .scl        (scl),
        .sda        (sda),
        .ack_enable (ack_enable)
    );

    bind eeprom_wr_top eeprom_wr_checker u_checker (
        .CLK   (CLK),
        .RESET (RESET),
        .busy  (busy),
        .done  (done),
        .scl   (scl),
        .sda   (sda)
    );

    always #4 CLK = ~CLK;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic eeprom_data_t ref_read(eeprom_addr_t a);
        return shadow[a];
    endfunction

    task automatic stop_on(string what);
        $display("%s at %0t", what, $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_data(string name, eeprom_data_t exp, eeprom_data_t act);
        if (act !== exp)
        begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp)
        begin
            $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // compares every response against the queued expectation
    always @(negedge CLK)
    begin
        if (RESET !== 1'b1 && done === 1'b1)
        begin
            if (exp_nack_q.size() == 0)
                stop_on("done pulsed with no request outstanding");
            else
            begin
                check_flag("rsp.nack", exp_nack_q[0], rsp.nack);
                if (exp_read_q[0] && !exp_nack_q[0])
                    check_data("rsp.rdata", exp_rdata_q[0], rsp.rdata);
                void'(exp_nack_q.pop_front());
                void'(exp_read_q.pop_front());
                void'(exp_rdata_q.pop_front());
                done_count++;
            end
        end
    end

    task automatic wait_done();
        int n;
        n = 0;
        while (done !== 1'b1)
        begin
            if (n >= TIMEOUT)
                stop_on("timeout waiting for done");
            else
            begin
                @(negedge CLK);
                n++;
            end
        end
    endtask

    task automatic issue(eeprom_op_e op, eeprom_addr_t addr, eeprom_data_t wdata, logic nack);
        @(negedge CLK);
        req_valid  = 1'b1;
        req.op     = op;
        req.addr   = addr;
        req.wdata  = wdata;
        exp_read_q.push_back(op == OP_READ);
        exp_nack_q.push_back(nack);
        exp_rdata_q.push_back(ref_read(addr));
        if (op == OP_WRITE && !nack)
            shadow[addr] = wdata;
        issued++;
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    task automatic transfer(eeprom_op_e op, eeprom_addr_t addr, eeprom_data_t wdata, logic nack);
        issue(op, addr, wdata, nack);
        wait_done();
    endtask

    initial
    begin
        eeprom_addr_t a;
        eeprom_addr_t b;
        int n;
        req_valid  = 1'b0;
        req        = '0;
        ack_enable = 1'b1;
        RESET      = 1'b1;
        lcg_state  = 32'hc6ef;
        done_count = 0;
        issued     = 0;
        for (int i = 0; i < 2048; i++)
            shadow[i] = i[7:0] ^ {i[10:8], 5'd0};   // model power-up contents
        repeat (16) @(negedge CLK);
        RESET = 1'b0;

        repeat (20)
        begin
            @(negedge CLK);
            check_flag("scl", 1'b1, scl);
            check_flag("sda", 1'b1, sda);
            check_flag("busy", 1'b0, busy);
            check_flag("done", 1'b0, done);
        end

        transfer(OP_WRITE, 11'h5a3, 8'h3c, 1'b0);
        transfer(OP_READ, 11'h5a3, 8'h00, 1'b0);

        for (int i = 0; i < 50; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            a = {i[2:0], lcg_state[23:16]};     // walks all eight blocks
            transfer(OP_WRITE, a, lcg_state[15:8], 1'b0);
            lcg_state = lcg_next(lcg_state);
            if (lcg_state[20])
                b = a;
            else
                b = lcg_state[26:16];
            transfer(OP_READ, b, 8'h00, 1'b0);
        end

        // slave silent so the shadow stays
        @(negedge CLK);
        ack_enable = 1'b0;
        transfer(OP_WRITE, 11'h5a3, 8'hc3, 1'b1);
        transfer(OP_READ, 11'h5a3, 8'h00, 1'b1);
        @(negedge CLK);
        ack_enable = 1'b1;
        transfer(OP_READ, 11'h5a3, 8'h00, 1'b0);

        issue(OP_WRITE, 11'h17e, 8'h81, 1'b0);
        repeat (10) @(negedge CLK);
        check_flag("busy", 1'b1, busy);
        req_valid = 1'b1;
        req.op    = OP_WRITE;
        req.addr  = 11'h2e1;
        req.wdata = 8'h42;
        @(negedge CLK);
        req_valid = 1'b0;
        wait_done();
        n = 0;
        while (n < 400)
        begin
            @(negedge CLK);
            n++;
        end
        transfer(OP_READ, 11'h17e, 8'h00, 1'b0);
        transfer(OP_READ, 11'h2e1, 8'h00, 1'b0);

        repeat (4) @(negedge CLK);
        if (exp_nack_q.size() == 0 && done_count == issued)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("responses received %0d of %0d requests", done_count, issued);
            $display("SOME TESTS FAILED");
            $fatal(1, "missing responses");
        end
    end

endmodule
